// File: verilog/vchess_defs.svh
`ifndef VCHESS_DEFS_SVH
`define VCHESS_DEFS_SVH

// piece codes, bit 3 set for black.
`define EMPTY_POSN 4'd0
`define WHITE_PAWN 4'd1
`define WHITE_ROOK 4'd2
`define WHITE_KNIT 4'd3
`define WHITE_BISH 4'd4
`define WHITE_KING 4'd5
`define WHITE_QUEN 4'd6

`define BLACK_PAWN 4'd9
`define BLACK_ROOK 4'd10
`define BLACK_KNIT 4'd11
`define BLACK_BISH 4'd12
`define BLACK_KING 4'd13
`define BLACK_QUEN 4'd14

// board geometry.
`define PIECE_WIDTH 4
`define SIDE_WIDTH  (`PIECE_WIDTH * 8)
`define BOARD_WIDTH (`SIDE_WIDTH * 8)

// square 0 is a1 in the low bits, rank 8 in the top 32 bits.

// sink buffer depth in characters.
`define CHAR_CREDITS 4

`endif

// File: verilog/vchess_pkg.sv
`include "vchess_defs.svh"

package vchess_pkg;

   typedef logic [`PIECE_WIDTH-1:0] piece_t;
   typedef logic [`BOARD_WIDTH-1:0] board_t;

   typedef logic [3:0] castle_t;     // one bit per castle right.
   typedef logic [3:0] ep_col_t;

   typedef logic [7:0] char_t;       // ascii.
   typedef logic [2:0] credit_t;     // holds 0 to CHAR_CREDITS.

   typedef enum logic [2:0]
   {
      st_idle,
      st_squares,
      st_check_line,
      st_status_line,
      st_blank_line,
      st_done
   } render_state_t;

endpackage

// File: verilog/board_snapshot.sv
module board_snapshot
   (
   input  logic                clk,
   input  logic                reset,

   input  logic                display,
   input  vchess_pkg::board_t  board,
   input  vchess_pkg::castle_t castle_mask,
   input  vchess_pkg::ep_col_t en_passant_col,
   input  logic                white_in_check,
   input  logic                black_in_check,
   input  logic                render_done,

   output logic                busy,
   output logic                start,
   output vchess_pkg::board_t  snap_board,
   output vchess_pkg::castle_t snap_castle,
   output vchess_pkg::ep_col_t snap_ep,
   output logic                snap_white_check,
   output logic                snap_black_check
   );

   logic accept;

   assign accept = display && !busy;   // requests while busy are dropped.

   always_ff @(posedge clk)
      if (reset)
      begin
         busy  <= 1'b0;
         start <= 1'b0;
      end
      else
      begin
         start <= accept;
         if (accept)
            busy <= 1'b1;
         else if (render_done)
            busy <= 1'b0;
      end

   // the engine may change its board freely once this copy is taken
   always_ff @(posedge clk)
      if (accept)
      begin
         snap_board       <= board;
         snap_castle      <= castle_mask;
         snap_ep          <= en_passant_col;
         snap_white_check <= white_in_check;
         snap_black_check <= black_in_check;
      end

endmodule

// File: verilog/display_board.sv
`include "vchess_defs.svh"

module display_board
   (
   input  logic                clk,
   input  logic                reset,

   input  logic                start,
   input  vchess_pkg::board_t  snap_board,
   input  vchess_pkg::castle_t snap_castle,
   input  vchess_pkg::ep_col_t snap_ep,
   input  logic                snap_white_check,
   input  logic                snap_black_check,

   input  logic                glyph_take,
   output logic                glyph_valid,
   output vchess_pkg::char_t   glyph,
   output logic                render_done
   );

   import vchess_pkg::*;

   localparam int idx_w = $clog2(`BOARD_WIDTH);

   localparam logic [idx_w-1:0] top_row    = idx_w'(`SIDE_WIDTH * 7);
   localparam logic [idx_w-1:0] side_step  = idx_w'(`SIDE_WIDTH);
   localparam logic [idx_w-1:0] piece_step = idx_w'(`PIECE_WIDTH);

   // text lines, left aligned.
   localparam logic [8*16-1:0] white_msg   = "White in check.\n";
   localparam logic [8*16-1:0] black_msg   = "Black in check.\n";
   localparam logic [8*16-1:0] both_msg    = {"Both in check!\n", 8'h00};
   localparam logic [8*28-1:0] status_tmpl = "castle=____ en_passant=____\n";

   render_state_t    state;
   logic [idx_w-1:0] index;
   logic [idx_w-1:0] row_start;
   logic [2:0]       col;
   logic [4:0]       char_idx;    // position within the current text line.
   logic [4:0]       check_last;
   logic [4:0]       castle_rel;
   logic [4:0]       ep_rel;
   logic [8*16-1:0]  check_msg;
   piece_t           piece;

   function automatic char_t piece_glyph(input piece_t p);
      case (p)
         `EMPTY_POSN: piece_glyph = ".";
         `WHITE_PAWN: piece_glyph = "P";
         `WHITE_ROOK: piece_glyph = "R";
         `WHITE_KNIT: piece_glyph = "N";
         `WHITE_BISH: piece_glyph = "B";
         `WHITE_KING: piece_glyph = "K";
         `WHITE_QUEN: piece_glyph = "Q";
         `BLACK_PAWN: piece_glyph = "p";
         `BLACK_ROOK: piece_glyph = "r";
         `BLACK_KNIT: piece_glyph = "n";
         `BLACK_BISH: piece_glyph = "b";
         `BLACK_KING: piece_glyph = "k";
         `BLACK_QUEN: piece_glyph = "q";
         default:     piece_glyph = "?";   // unused code.
      endcase
   endfunction

   assign piece       = snap_board[index +: `PIECE_WIDTH];
   assign glyph_valid = (state == st_squares) || (state == st_check_line) ||
                        (state == st_status_line) || (state == st_blank_line);
   assign render_done = (state == st_done);

   assign check_msg  = (snap_white_check && snap_black_check) ? both_msg :
                       snap_white_check ? white_msg : black_msg;
   assign check_last = (snap_white_check && snap_black_check) ? 5'd14 : 5'd15;
   assign castle_rel = char_idx - 5'd7;
   assign ep_rel     = char_idx - 5'd23;

   always_comb
   begin
      glyph = 8'h0a;
      case (state)
         st_squares:
            if (char_idx == 5'd0)
               glyph = piece_glyph(piece);
            else if (char_idx == 5'd1)
               glyph = " ";
         st_check_line:
            glyph = check_msg[8 * (5'd15 - char_idx) +: 8];
         st_status_line:
            if (char_idx >= 5'd7 && char_idx <= 5'd10)
               glyph = {7'b0011000, snap_castle[~castle_rel[1:0]]};   // msb first.
            else if (char_idx >= 5'd23 && char_idx <= 5'd26)
               glyph = {7'b0011000, snap_ep[~ep_rel[1:0]]};
            else
               glyph = status_tmpl[8 * (5'd27 - char_idx) +: 8];
         default:
            glyph = 8'h0a;
      endcase
   end

   always_ff @(posedge clk)
      if (reset)
      begin
         state     <= st_idle;
         index     <= top_row;
         row_start <= top_row;
         col       <= 3'd0;
         char_idx  <= 5'd0;
      end
      else
         case (state)
            st_idle:
               if (start)
               begin
                  row_start <= top_row;
                  index     <= top_row;
                  col       <= 3'd0;
                  char_idx  <= 5'd0;
                  state     <= st_squares;
               end
            st_squares:
               if (glyph_take)
                  case (char_idx)
                     5'd0:
                        char_idx <= 5'd1;
                     5'd1:
                        if (col == 3'd7)
                           char_idx <= 5'd2;   // newline next.
                        else
                        begin
                           char_idx <= 5'd0;
                           col      <= col + 3'd1;
                           index    <= index + piece_step;
                        end
                     default:
                     begin
                        char_idx  <= 5'd0;
                        col       <= 3'd0;
                        row_start <= row_start - side_step;
                        index     <= row_start - side_step;
                        if (row_start == '0)
                           state <= (snap_white_check || snap_black_check) ?
                                    st_check_line : st_status_line;
                     end
                  endcase
            st_check_line:
               if (glyph_take)
               begin
                  if (char_idx == check_last)
                  begin
                     char_idx <= 5'd0;
                     state    <= st_status_line;
                  end
                  else
                     char_idx <= char_idx + 5'd1;
               end
            st_status_line:
               if (glyph_take)
               begin
                  if (char_idx == 5'd27)
                  begin
                     char_idx <= 5'd0;
                     state    <= st_blank_line;
                  end
                  else
                     char_idx <= char_idx + 5'd1;
               end
            st_blank_line:
               if (glyph_take)
                  state <= st_done;
            default:
               state <= st_idle;
         endcase

endmodule

// File: verilog/char_credit_tx.sv
`include "vchess_defs.svh"

module char_credit_tx
   (
   input  logic              clk,
   input  logic              reset,

   input  logic              glyph_valid,
   input  vchess_pkg::char_t glyph,
   input  logic              render_done,
   output logic              glyph_take,

   output logic              char_valid,
   output vchess_pkg::char_t char_data,
   input  logic              credit_return,
   output logic              display_done
   );

   import vchess_pkg::*;

   credit_t credits;

   // a credit is spent when the glyph is accepted.
   assign glyph_take = glyph_valid && (credits != '0);

   always_ff @(posedge clk)
      if (reset)
         credits <= credit_t'(`CHAR_CREDITS);
      else
         case ({glyph_take, credit_return})
            2'b10:   credits <= credits - 3'd1;
            2'b01:   credits <= credits + 3'd1;
            default: credits <= credits;   // none, or spend and return together.
         endcase

   always_ff @(posedge clk)
      if (reset)
      begin
         char_valid   <= 1'b0;
         display_done <= 1'b0;
      end
      else
      begin
         char_valid   <= glyph_take;
         // render_done lines up with the last char_valid.
         display_done <= render_done;
      end

   always_ff @(posedge clk)
      if (glyph_take)
         char_data <= glyph;

endmodule

// File: verilog/chess_display_top.sv
module chess_display_top
   (
   input  logic                clk,
   input  logic                reset,

   input  vchess_pkg::board_t  board,
   input  vchess_pkg::castle_t castle_mask,
   input  vchess_pkg::ep_col_t en_passant_col,
   input  logic                white_in_check,
   input  logic                black_in_check,
   input  logic                display,

   output logic                char_valid,
   output vchess_pkg::char_t   char_data,
   input  logic                credit_return,

   output logic                display_done
   );

   import vchess_pkg::*;

   logic    start;
   board_t  snap_board;
   castle_t snap_castle;
   ep_col_t snap_ep;
   logic    snap_white_check;
   logic    snap_black_check;
   logic    render_done;
   logic    glyph_valid;
   char_t   glyph;
   logic    glyph_take;

   board_snapshot u_snapshot
      (
      .clk              (clk),
      .reset            (reset),
      .display          (display),
      .board            (board),
      .castle_mask      (castle_mask),
      .en_passant_col   (en_passant_col),
      .white_in_check   (white_in_check),
      .black_in_check   (black_in_check),
      .render_done      (render_done),
      .busy             (),
      .start            (start),
      .snap_board       (snap_board),
      .snap_castle      (snap_castle),
      .snap_ep          (snap_ep),
      .snap_white_check (snap_white_check),
      .snap_black_check (snap_black_check)
      );

   display_board u_render
      (
      .clk              (clk),
      .reset            (reset),
      .start            (start),
      .snap_board       (snap_board),
      .snap_castle      (snap_castle),
      .snap_ep          (snap_ep),
      .snap_white_check (snap_white_check),
      .snap_black_check (snap_black_check),
      .glyph_take       (glyph_take),
      .glyph_valid      (glyph_valid),
      .glyph            (glyph),
      .render_done      (render_done)
      );

   char_credit_tx u_tx
      (
      .clk           (clk),
      .reset         (reset),
      .glyph_valid   (glyph_valid),
      .glyph         (glyph),
      .render_done   (render_done),
      .glyph_take    (glyph_take),
      .char_valid    (char_valid),
      .char_data     (char_data),
      .credit_return (credit_return),
      .display_done  (display_done)
      );

endmodule

// File: sim/chess_display_properties.sv
`include "vchess_defs.svh"

module chess_display_properties
   (
   input logic                clk,
   input logic                reset,
   input logic                char_valid,
   input logic                credit_return,
   input logic                display_done,
   input vchess_pkg::credit_t credits
   );

   import vchess_pkg::*;

   int fail_count = 0;
   int sink_room;   // free sink entries as seen on the channel.

   always @(posedge clk)
      if (reset)
         sink_room <= `CHAR_CREDITS;
      else
         sink_room <= sink_room - int'(char_valid) + int'(credit_return);

   assert property (@(posedge clk) disable iff (reset) char_valid |-> sink_room > 0)
   else
   begin
      $error("character sent with no credit held");
      fail_count++;
   end

   assert property (@(posedge clk) disable iff (reset) credits <= credit_t'(`CHAR_CREDITS))
   else
   begin
      $error("credit count above the sink depth");
      fail_count++;
   end

   assert property (@(posedge clk) disable iff (reset) display_done |=> !display_done)
   else
   begin
      $error("display_done longer than one cycle");
      fail_count++;
   end

   // outputs clear once reset has been seen for a cycle.
   assert property (@(posedge clk) reset && $past(reset) |-> !char_valid && !display_done)
   else
   begin
      $error("channel active during reset");
      fail_count++;
   end

endmodule

bind chess_display_top chess_display_properties u_props
   (
   .clk           (clk),
   .reset         (reset),
   .char_valid    (char_valid),
   .credit_return (credit_return),
   .display_done  (display_done),
   .credits       (u_tx.credits)
   );

// File: sim/chess_display_tb.sv
`include "vchess_defs.svh"

module chess_display_tb;

   import vchess_pkg::*;

   localparam int num_renders = 14;
   localparam int max_hold    = 24;                  // long credit hold, in cycles.
   localparam int render_max  = 182 * (4 + max_hold);
   localparam int cycle_limit = num_renders * 182 * 4 + 182 * max_hold + 2000;

   logic    clk;
   logic    reset;
   board_t  board;
   castle_t castle_mask;
   ep_col_t en_passant_col;
   logic    white_in_check;
   logic    black_in_check;
   logic    display;
   logic    char_valid;
   char_t   char_data;
   logic    credit_return = 1'b0;
   logic    display_done;

   char_t rx_q[$];
   char_t exp_q[$];
   int    ret_q[$];                                  // cycles when credits go back.
   int    cycle = 0;
   int    done_count = 0;
   int    rx_base;
   int    done_base;
   int    errors;
   int    tests;
   int    failed_tests;
   bit    bp_mode;

   chess_display_top u_dut (.*);

   initial
   begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   always @(posedge clk)
   begin
      cycle = cycle + 1;
      if (cycle > cycle_limit)
      begin
         $display("timeout after %0d cycles, a diagram never finished", cycle_limit);
         $display("Regression failed");
         $finish;
      end
   end

   // sink model.
   always @(negedge clk)
   begin
      int due;
      credit_return = 1'b0;
      if (reset)
         ret_q.delete();
      else
      begin
         if (char_valid)
         begin
            rx_q.push_back(char_data);
            due = cycle + int'($urandom_range(3, 1));
            if (bp_mode && $urandom_range(3, 0) == 0)
               due = due + max_hold;                 // stalls every later credit too.
            if (ret_q.size() > 0 && due <= ret_q[$])
               due = ret_q[$] + 1;
            ret_q.push_back(due);
         end
         if (display_done)
            done_count = done_count + 1;
         if (ret_q.size() > 0 && ret_q[0] <= cycle)
         begin
            void'(ret_q.pop_front());
            credit_return = 1'b1;
         end
      end
   end

   function automatic char_t glyph_of(input piece_t p);
      string white_set;
      string black_set;
      white_set = "PRNBKQ";
      black_set = "prnbkq";
      if (p >= `WHITE_PAWN && p <= `WHITE_QUEN)
         glyph_of = white_set[p - `WHITE_PAWN];
      else if (p >= `BLACK_PAWN && p <= `BLACK_QUEN)
         glyph_of = black_set[p - `BLACK_PAWN];
      else
         glyph_of = ".";
   endfunction

   function automatic board_t start_board();
      board_t b;
      piece_t back[8];
      back = '{`WHITE_ROOK, `WHITE_KNIT, `WHITE_BISH, `WHITE_QUEN,
               `WHITE_KING, `WHITE_BISH, `WHITE_KNIT, `WHITE_ROOK};
      b = '0;
      for (int f = 0; f < 8; f++)
      begin
         b[f * 4 +: 4]        = back[f];
         b[(8 + f) * 4 +: 4]  = `WHITE_PAWN;
         b[(48 + f) * 4 +: 4] = `BLACK_PAWN;
         b[(56 + f) * 4 +: 4] = back[f] | 4'b1000;   // black has bit 3 set.
      end
      return b;
   endfunction

   function automatic board_t random_board();
      board_t b;
      int     k;
      for (int sq = 0; sq < 64; sq++)
      begin
         k = $urandom_range(12, 0);
         if (k == 0)
            b[sq * 4 +: 4] = `EMPTY_POSN;
         else if (k <= 6)
            b[sq * 4 +: 4] = piece_t'(`WHITE_PAWN + k - 1);
         else
            b[sq * 4 +: 4] = piece_t'(`BLACK_PAWN + k - 7);
      end
      return b;
   endfunction

   // expected text, rank 8 first and file a first.
   task automatic build_expected(input board_t b, input castle_t c, input ep_col_t e,
                                 input logic wc, input logic bc);
      string line;
      exp_q.delete();
      for (int r = 7; r >= 0; r--)
      begin
         for (int f = 0; f < 8; f++)
         begin
            exp_q.push_back(glyph_of(b[(r * 8 + f) * 4 +: 4]));
            exp_q.push_back(" ");
         end
         exp_q.push_back("\n");
      end
      if (wc && bc)
         line = "Both in check!\n";
      else if (wc)
         line = "White in check.\n";
      else if (bc)
         line = "Black in check.\n";
      else
         line = "";
      line = {line, $sformatf("castle=%b en_passant=%b\n\n", c, e)};
      for (int i = 0; i < line.len(); i++)
         exp_q.push_back(line[i]);
   endtask

   task automatic send_request(input board_t b, input castle_t c, input ep_col_t e,
                               input logic wc, input logic bc);
      build_expected(b, c, e, wc, bc);
      rx_base   = rx_q.size();
      done_base = done_count;
      @(negedge clk);
      board          = b;
      castle_mask    = c;
      en_passant_col = e;
      white_in_check = wc;
      black_in_check = bc;
      display        = 1'b1;
      @(negedge clk);
      display = 1'b0;
   endtask

   task automatic wait_done();
      int waited;
      waited = 0;
      while (done_count == done_base && waited < render_max)
      begin
         @(posedge clk);
         waited++;
      end
   endtask

   task automatic check_result(input string name);
      int bad;
      int got;
      bad = 0;
      got = rx_q.size() - rx_base;
      assert (done_count == done_base + 1)
      else
      begin
         $display("%s: display_done did not pulse exactly once", name);
         bad++;
      end
      assert (got == exp_q.size())
      else
      begin
         $display("CHECK FAILED %s char count: got %h expected %h", name, got, exp_q.size());
         bad++;
      end
      for (int i = 0; i < got && i < exp_q.size(); i++)
         assert (rx_q[rx_base + i] == exp_q[i])
         else
         begin
            if (bad < 4)
               $display("CHECK FAILED %s char_data[%0d]: got %h expected %h",
                        name, i, rx_q[rx_base + i], exp_q[i]);
            bad++;
         end
      errors = errors + bad;
      tests  = tests + 1;
      if (bad != 0)
         failed_tests = failed_tests + 1;
      $display("test %-14s %0d chars, %0d errors", name, got, bad);
   endtask

   task automatic render(input string name, input board_t b, input castle_t c,
                         input ep_col_t e, input logic wc, input logic bc);
      send_request(b, c, e, wc, bc);
      wait_done();
      check_result(name);
   endtask

   task automatic busy_drop();
      send_request(start_board(), 4'b0101, 4'b0010, 1'b0, 1'b1);
      while (rx_q.size() - rx_base < 20)
         @(negedge clk);
      board          = random_board();
      castle_mask    = 4'b1110;
      white_in_check = 1'b1;
      display        = 1'b1;
      @(negedge clk);
      display = 1'b0;
      wait_done();
      repeat (40) @(negedge clk);                    // room for a stray second diagram.
      check_result("busy_drop");
   endtask

   task automatic reset_mid_render();
      int bad;
      bad = 0;
      send_request(random_board(), 4'b1010, 4'b0011, 1'b1, 1'b0);
      while (rx_q.size() - rx_base < 40)
         @(negedge clk);
      reset = 1'b1;
      repeat (4) @(negedge clk);
      reset = 1'b0;
      repeat (30)
      begin
         @(negedge clk);
         assert (!char_valid && !display_done)
         else
         begin
            $display("CHECK FAILED reset char_valid %h display_done %h expected 0",
                     char_valid, display_done);
            bad++;
         end
      end
      errors = errors + bad;
      tests  = tests + 1;
      if (bad != 0)
         failed_tests = failed_tests + 1;
      $display("test %-14s %0d errors", "reset_quiet", bad);
      render("after_reset", random_board(), 4'b0111, 4'b1000, 1'b0, 1'b1);
   endtask

   initial
   begin
      board_t b;
      void'($urandom(68));
      reset          = 1'b1;
      display        = 1'b0;
      board          = '0;
      castle_mask    = '0;
      en_passant_col = '0;
      white_in_check = 1'b0;
      black_in_check = 1'b0;
      bp_mode        = 1'b0;
      errors         = 0;
      tests          = 0;
      failed_tests   = 0;
      repeat (4) @(negedge clk);
      reset = 1'b0;
      render("start_pos", start_board(), 4'b1111, 4'b0000, 1'b0, 1'b0);
      b = random_board();
      for (int k = 0; k < 4; k++)
         render($sformatf("check_w%0d_b%0d", k % 2, k / 2), b, 4'b0110, 4'b0101, k[0], k[1]);
      for (int t = 0; t < 5; t++)
         render($sformatf("random_%0d", t), random_board(), castle_t'($urandom_range(15, 0)),
                ep_col_t'($urandom_range(15, 0)), 1'b0, 1'b0);
      bp_mode = 1'b1;
      render("back_pressure", random_board(), 4'b1001, 4'b0111, 1'b1, 1'b1);
      bp_mode = 1'b0;
      busy_drop();
      reset_mid_render();
      errors = errors + u_dut.u_props.fail_count;
      $display("%0d tests, %0d failed, %0d errors", tests, failed_tests, errors);
      if (errors == 0)
         $display("Regression passed");
      else
         $display("Regression failed");
      $finish;
   end

endmodule

// File: chess_display_top.f
+incdir+verilog
verilog/vchess_pkg.sv
verilog/board_snapshot.sv
verilog/display_board.sv
verilog/char_credit_tx.sv
verilog/chess_display_top.sv
sim/chess_display_properties.sv
sim/chess_display_tb.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module chess_display_tb \
   -f chess_display_top.f -Mdir obj_dir
./obj_dir/Vchess_display_tb +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log
if grep -q "Regression failed" sim.log; then
   exit 1
fi
exit 0
